//--- Makefile
# Verilator flow for the integer execute slice

VERILATOR  ?= verilator
TOP        ?= tb_exec_core
RTL_TOP    ?= exec_core
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
RTL_SRCS   ?= source/isa_pkg.sv source/core_pkg.sv source/decode_if.sv \
              source/reg_file.sv source/inst_decoder.sv source/alu.sv \
              source/exec_core.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) +incdir+source $(RTL_SRCS) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
+incdir+source
source/isa_pkg.sv
source/core_pkg.sv
source/decode_if.sv
source/reg_file.sv
source/inst_decoder.sv
source/alu.sv
source/exec_core.sv
testbench/exec_core_props.sv
testbench/exec_core_checker.sv
testbench/tb_exec_core.sv

//--- source/alu.sv
/*
 * Integer ALU
 * Computes all results in parallel and picks one by operation key
 */
`timescale 1ns/100ps

module alu (
  input  core_pkg::alu_op_e op,
  input  core_pkg::xlen_t   a,
  input  core_pkg::xlen_t   b,
  output core_pkg::xlen_t   result
);
  import core_pkg::*;

  localparam int NUM_OPS = ALU_PASS_B + 1;

  xlen_t  cand [NUM_OPS];
  shamt_t shamt;

  assign shamt = b[SHAMT_W-1:0];

  assign cand[ALU_ADD]    = a + b;
  assign cand[ALU_SUB]    = a - b;
  assign cand[ALU_SLL]    = a << shamt;
  assign cand[ALU_SLT]    = xlen_t'($signed(a) < $signed(b));
  assign cand[ALU_SLTU]   = xlen_t'(a < b);
  assign cand[ALU_XOR]    = a ^ b;
  assign cand[ALU_SRL]    = a >> shamt;
  assign cand[ALU_SRA]    = xlen_t'($signed(a) >>> shamt);
  assign cand[ALU_OR]     = a | b;
  assign cand[ALU_AND]    = a & b;
  assign cand[ALU_PASS_B] = b;

  // key match gates each candidate, hits are OR-ed together
  always_comb begin
    result = '0;
    for (int k = 0; k < NUM_OPS; k++) begin
      result = result | ({$bits(xlen_t){op == alu_op_e'(k)}} & cand[k]);
    end
  end

endmodule

//--- source/core_config.svh
/*
 * Core configuration
 * Global widths and sizes for the integer execute slice
 */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define XLEN       32
`define NUM_REGS   32
`define REG_ADDR_W 5

`endif

//--- source/core_pkg.sv
/*
 * Core datapath types
 * Data word, register address, shift amount and ALU operation key
 */
`include "core_config.svh"

package core_pkg;

  localparam int SHAMT_W  = 5;
  localparam int ALU_OP_W = 4;

  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [SHAMT_W-1:0]     shamt_t;

  // operation key seen by the ALU
  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

endpackage

//--- source/decode_if.sv
/*
 * Decoded instruction bundle
 * Carries one decoded word from the decoder into the execute stage
 */
`timescale 1ns/100ps

interface decode_if;
  import core_pkg::*;

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  xlen_t     imm;
  alu_op_e   alu_op;
  logic      use_imm;
  logic      writes_rd;
  logic      illegal;

  modport producer (
    output rs1, rs2, rd, imm, alu_op,
    output use_imm, writes_rd, illegal
  );

  // execute side only samples the fields
  modport consumer (
    input rs1, rs2, rd, imm, alu_op,
    input use_imm, writes_rd, illegal
  );

endinterface

//--- source/exec_core.sv
/*
 * Integer execute slice
 * Accepts one word per transfer, decodes and reads operands with
 * bypass, executes one cycle later and retires through the output port
 */
`timescale 1ns/100ps

module exec_core (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  isa_pkg::inst_t      inst,
  output logic                out_valid,
  input  logic                out_ready,
  output core_pkg::reg_addr_t out_rd,
  output core_pkg::xlen_t     out_result,
  output logic                out_illegal
);
  import core_pkg::*;

  // stage register contents
  logic      stage_valid;
  reg_addr_t stage_rd;
  alu_op_e   stage_op;
  xlen_t     stage_a;
  xlen_t     stage_b;
  logic      stage_writes_rd;
  logic      stage_illegal;

  logic  accept;
  logic  retire;
  logic  wen;
  logic  byp_rs1;
  logic  byp_rs2;
  xlen_t rs1_data;
  xlen_t rs2_data;
  xlen_t opnd_a;
  xlen_t opnd_b;
  xlen_t alu_result;

  decode_if dec ();

  inst_decoder u_decoder (
    .inst (inst),
    .dec  (dec)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (dec.rs1),
    .rs2_addr (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (wen),
    .waddr    (stage_rd),
    .wdata    (alu_result)
  );

  alu u_alu (
    .op     (stage_op),
    .a      (stage_a),
    .b      (stage_b),
    .result (alu_result)
  );

  // handshake, stage frees up in the cycle it retires
  assign retire   = stage_valid && out_ready;
  assign in_ready = !stage_valid || out_ready;
  assign accept   = in_valid && in_ready;

  assign wen = retire && stage_writes_rd && !stage_illegal;

  // forward the retiring result, x0 always reads zero
  assign byp_rs1 = wen && (dec.rs1 == stage_rd) && (dec.rs1 != '0);
  assign byp_rs2 = wen && (dec.rs2 == stage_rd) && (dec.rs2 != '0);

  assign opnd_a = byp_rs1 ? alu_result : rs1_data;

  always_comb begin
    if (dec.use_imm) begin
      opnd_b = dec.imm;
    end else if (byp_rs2) begin
      opnd_b = alu_result;
    end else begin
      opnd_b = rs2_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
    end else if (in_ready) begin
      stage_valid <= in_valid;
    end
  end

  // payload loads only on acceptance and holds under back-pressure
  always_ff @(posedge clk) begin
    if (accept) begin
      stage_rd        <= dec.rd;
      stage_op        <= dec.alu_op;
      stage_a         <= opnd_a;
      stage_b         <= opnd_b;
      stage_writes_rd <= dec.writes_rd;
      stage_illegal   <= dec.illegal;
    end
  end

  assign out_valid   = stage_valid;
  assign out_rd      = stage_rd;
  assign out_illegal = stage_illegal;
  assign out_result  = stage_illegal ? '0 : alu_result;

endmodule

//--- source/inst_decoder.sv
/*
 * Instruction decoder
 * Splits an RV32I word into register addresses, immediate and ALU key,
 * and flags anything outside the supported subset as illegal
 */
`timescale 1ns/100ps
`include "core_config.svh"

module inst_decoder (
  input isa_pkg::inst_t inst,
  decode_if.producer    dec
);
  import isa_pkg::*;
  import core_pkg::*;

  opcode_e opcode;
  funct3_t funct3;
  funct7_t funct7;
  xlen_t   imm_i;
  xlen_t   imm_u;

  assign opcode = opcode_e'(inst[OPCODE_LSB +: 7]);
  assign funct3 = inst[FUNCT3_LSB +: 3];
  assign funct7 = inst[FUNCT7_LSB +: 7];

  // sign-extended I-type and zero-filled U-type immediates
  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};

  // key for the funct7 == 0 encodings, shared by OP and OP-IMM
  function automatic alu_op_e base_op(funct3_t f3);
    case (f3)
      F3_ADD_SUB: base_op = ALU_ADD;
      F3_SLL:     base_op = ALU_SLL;
      F3_SLT:     base_op = ALU_SLT;
      F3_SLTU:    base_op = ALU_SLTU;
      F3_XOR:     base_op = ALU_XOR;
      F3_SRL_SRA: base_op = ALU_SRL;
      F3_OR:      base_op = ALU_OR;
      F3_AND:     base_op = ALU_AND;
    endcase
  endfunction

  always_comb begin
    dec.rs1       = inst[RS1_LSB +: `REG_ADDR_W];
    dec.rs2       = inst[RS2_LSB +: `REG_ADDR_W];
    dec.rd        = inst[RD_LSB +: `REG_ADDR_W];
    dec.imm       = imm_i;
    dec.alu_op    = base_op(funct3);
    dec.use_imm   = 1'b0;
    dec.writes_rd = 1'b1;
    dec.illegal   = 1'b0;

    case (opcode)
      OP: begin
        if (funct7 == F7_ALT && funct3 == F3_ADD_SUB) begin
          dec.alu_op = ALU_SUB;
        end else if (funct7 == F7_ALT && funct3 == F3_SRL_SRA) begin
          dec.alu_op = ALU_SRA;
        end else if (funct7 != F7_BASE) begin
          dec.illegal = 1'b1;
        end
      end
      OP_IMM: begin
        dec.use_imm = 1'b1;
        // only the shifts reuse funct7, as the shamt upper field
        if (funct3 == F3_SRL_SRA && funct7 == F7_ALT) begin
          dec.alu_op = ALU_SRA;
        end else if ((funct3 == F3_SLL || funct3 == F3_SRL_SRA) && funct7 != F7_BASE) begin
          dec.illegal = 1'b1;
        end
      end
      LUI: begin
        dec.rs1     = '0;
        dec.imm     = imm_u;
        dec.alu_op  = ALU_PASS_B;
        dec.use_imm = 1'b1;
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase

    // nothing retires into the file for a bad word
    if (dec.illegal) begin
      dec.writes_rd = 1'b0;
    end
  end

endmodule

//--- source/isa_pkg.sv
/*
 * RV32I instruction encodings
 * Word type, major opcodes and funct codes for the supported subset
 */
package isa_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // major opcodes handled by the slice
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
  } opcode_e;

  // funct3 for OP and OP-IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // funct7 values, alt selects sub and sra
  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000;

  // field positions inside the word
  localparam int OPCODE_LSB = 0;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

endpackage

//--- source/reg_file.sv
/*
 * Integer register file
 * Two combinational read ports, one write port, x0 reads as zero
 */
`timescale 1ns/100ps
`include "core_config.svh"

module reg_file (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  output core_pkg::xlen_t     rs1_data,
  output core_pkg::xlen_t     rs2_data,
  input  logic               wen,
  input  core_pkg::reg_addr_t waddr,
  input  core_pkg::xlen_t     wdata
);
  import core_pkg::*;

  xlen_t regs [`NUM_REGS];

  // x0 is hardwired, storage behind it never shows
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

//--- testbench/exec_core_checker.sv
/*
 * Result checker
 * Compares every output transfer with the next expected table entry
 */
`timescale 1ns/100ps

module exec_core_checker #(
  parameter int NUM_TESTS = 1
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                out_valid,
  input  logic                out_ready,
  input  core_pkg::reg_addr_t out_rd,
  input  core_pkg::xlen_t     out_result,
  input  logic                out_illegal,
  input  core_pkg::reg_addr_t exp_rd      [NUM_TESTS],
  input  core_pkg::xlen_t     exp_result  [NUM_TESTS],
  input  logic                exp_illegal [NUM_TESTS],
  output int                  error_count,
  output int                  result_count
);

  initial begin
    error_count  = 0;
    result_count = 0;
  end

  task automatic check_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s entry %0d expected 0x%08h actual 0x%08h",
               name, result_count, expected, actual);
      error_count++;
    end
  endtask

  // results leave strictly in table order
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (result_count >= NUM_TESTS) begin
        $display("unexpected extra result for rd %0d after the table ended", out_rd);
        error_count++;
      end else begin
        check_field("out_rd", 32'(exp_rd[result_count]), 32'(out_rd));
        check_field("out_result", exp_result[result_count], out_result);
        check_field("out_illegal", 32'(exp_illegal[result_count]), 32'(out_illegal));
      end
      result_count++;
    end
  end

endmodule

//--- testbench/exec_core_props.sv
/*
 * Execute slice properties
 * Output hold under stall, reset state, latency and register write rules
 */
`timescale 1ns/100ps

module exec_core_props (
  input logic                clk,
  input logic                rst,
  input logic                in_valid,
  input logic                in_ready,
  input logic                out_valid,
  input logic                out_ready,
  input core_pkg::reg_addr_t out_rd,
  input core_pkg::xlen_t     out_result,
  input logic                out_illegal,
  input logic                wen
);

  // a stalled result must not move
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=>
      out_valid && $stable(out_rd) && $stable(out_result) && $stable(out_illegal))
    else $error("output port changed while stalled");

  a_reset_empty: assert property (@(posedge clk) rst |=> !out_valid && in_ready)
    else $error("stage not empty after reset");

  // an accepted word is on the output one cycle later
  a_latency: assert property (@(posedge clk) disable iff (rst)
    in_valid && in_ready |=> out_valid)
    else $error("accepted word did not reach the output one cycle later");

  // every legal output transfer retires into the file
  a_write_rule: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready && !out_illegal |-> wen)
    else $error("legal retire without a register write");

endmodule

bind exec_core exec_core_props u_props (
  .clk         (clk),
  .rst         (rst),
  .in_valid    (in_valid),
  .in_ready    (in_ready),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .out_rd      (out_rd),
  .out_result  (out_result),
  .out_illegal (out_illegal),
  .wen         (wen)
);

//--- testbench/tb_exec_core.sv
/*
 * Testbench for the integer execute slice
 * Runs a fixed instruction table through the DUT with random output stalls
 */
`timescale 1ns/100ps

module tb_exec_core;
  import isa_pkg::*;
  import core_pkg::*;

  localparam int NUM_TESTS       = 30;
  localparam int RESET_CYCLES    = 2;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 20;

  logic        clk;
  logic        rst          = 1'b1;
  logic        in_valid     = 1'b0;
  inst_t       inst         = '0;
  logic        out_ready    = 1'b1;
  logic        random_phase = 1'b0;
  logic        in_ready;
  logic        out_valid;
  reg_addr_t   out_rd;
  xlen_t       out_result;
  logic        out_illegal;
  inst_t       inst_tab        [NUM_TESTS];
  reg_addr_t   exp_rd_tab      [NUM_TESTS];
  xlen_t       exp_result_tab  [NUM_TESTS];
  logic        exp_illegal_tab [NUM_TESTS];
  int          fill_count = 0;
  int          error_count;
  int          result_count;
  int          seed = 82083;
  logic [31:0] rnd;

  exec_core u_dut (
    .clk (clk), .rst (rst),
    .in_valid (in_valid), .in_ready (in_ready), .inst (inst),
    .out_valid (out_valid), .out_ready (out_ready), .out_rd (out_rd),
    .out_result (out_result), .out_illegal (out_illegal)
  );

  exec_core_checker #(.NUM_TESTS (NUM_TESTS)) u_checker (
    .clk (clk), .rst (rst),
    .out_valid (out_valid), .out_ready (out_ready), .out_rd (out_rd),
    .out_result (out_result), .out_illegal (out_illegal),
    .exp_rd (exp_rd_tab), .exp_result (exp_result_tab), .exp_illegal (exp_illegal_tab),
    .error_count (error_count), .result_count (result_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic inst_t r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic inst_t i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic inst_t u_type_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic add_entry(input inst_t word, input reg_addr_t rd, input xlen_t result,
                           input logic illegal);
    inst_tab[fill_count]        = word;
    exp_rd_tab[fill_count]      = rd;
    exp_result_tab[fill_count]  = result;
    exp_illegal_tab[fill_count] = illegal;
    fill_count++;
  endtask

  task automatic fill_table();
    // x0 reads zero, writes to it vanish
    add_entry(r_type_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd5), 5'd5, 32'h0000_0000, 1'b0);
    add_entry(i_type_word(12'h007, 5'd0, 3'b000, 5'd0), 5'd0, 32'h0000_0007, 1'b0);
    add_entry(r_type_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd6), 5'd6, 32'h0000_0000, 1'b0);
    // chains, each word reads the previous rd
    add_entry(i_type_word(12'hffb, 5'd0, 3'b000, 5'd1), 5'd1, 32'hffff_fffb, 1'b0);
    add_entry(i_type_word(12'hfff, 5'd1, 3'b000, 5'd2), 5'd2, 32'hffff_fffa, 1'b0);
    add_entry(u_type_word(20'h12345, 5'd8), 5'd8, 32'h1234_5000, 1'b0);
    add_entry(i_type_word(12'h678, 5'd8, 3'b000, 5'd8), 5'd8, 32'h1234_5678, 1'b0);
    add_entry(r_type_word(7'h00, 5'd8, 5'd8, 3'b000, 5'd9), 5'd9, 32'h2468_acf0, 1'b0);
    add_entry(r_type_word(7'h20, 5'd8, 5'd9, 3'b000, 5'd10), 5'd10, 32'h1234_5678, 1'b0);
    add_entry(r_type_word(7'h00, 5'd8, 5'd10, 3'b100, 5'd11), 5'd11, 32'h0000_0000, 1'b0);
    // immediate logic and compares around the sign boundary
    add_entry(i_type_word(12'h0f0, 5'd1, 3'b100, 5'd3), 5'd3, 32'hffff_ff0b, 1'b0);
    add_entry(i_type_word(12'h7ff, 5'd0, 3'b110, 5'd4), 5'd4, 32'h0000_07ff, 1'b0);
    add_entry(i_type_word(12'h0ff, 5'd1, 3'b111, 5'd7), 5'd7, 32'h0000_00fb, 1'b0);
    add_entry(i_type_word(12'hffc, 5'd1, 3'b010, 5'd12), 5'd12, 32'h0000_0001, 1'b0);
    add_entry(i_type_word(12'h005, 5'd1, 3'b011, 5'd13), 5'd13, 32'h0000_0000, 1'b0);
    add_entry(i_type_word(12'h800, 5'd0, 3'b011, 5'd14), 5'd14, 32'h0000_0001, 1'b0);
    add_entry(u_type_word(20'h80000, 5'd15), 5'd15, 32'h8000_0000, 1'b0);
    add_entry(i_type_word(12'h000, 5'd15, 3'b010, 5'd16), 5'd16, 32'h0000_0001, 1'b0);
    // register-register forms, shift amount in x18
    add_entry(i_type_word(12'h004, 5'd0, 3'b000, 5'd18), 5'd18, 32'h0000_0004, 1'b0);
    add_entry(r_type_word(7'h00, 5'd18, 5'd8, 3'b001, 5'd17), 5'd17, 32'h2345_6780, 1'b0);
    add_entry(r_type_word(7'h00, 5'd18, 5'd15, 3'b101, 5'd19), 5'd19, 32'h0800_0000, 1'b0);
    add_entry(r_type_word(7'h20, 5'd18, 5'd15, 3'b101, 5'd20), 5'd20, 32'hf800_0000, 1'b0);
    add_entry(i_type_word(12'h401, 5'd1, 3'b101, 5'd21), 5'd21, 32'hffff_fffd, 1'b0);
    add_entry(r_type_word(7'h00, 5'd18, 5'd1, 3'b010, 5'd22), 5'd22, 32'h0000_0001, 1'b0);
    add_entry(r_type_word(7'h00, 5'd18, 5'd1, 3'b011, 5'd23), 5'd23, 32'h0000_0000, 1'b0);
    add_entry(r_type_word(7'h00, 5'd15, 5'd8, 3'b110, 5'd24), 5'd24, 32'h9234_5678, 1'b0);
    add_entry(r_type_word(7'h00, 5'd8, 5'd3, 3'b111, 5'd25), 5'd25, 32'h1234_5608, 1'b0);
    // sw and mul are outside the subset, x9 and x12 keep old values
    add_entry({7'h00, 5'd8, 5'd10, 3'b010, 5'd9, 7'b0100011}, 5'd9, 32'h0000_0000, 1'b1);
    add_entry(r_type_word(7'h01, 5'd1, 5'd1, 3'b000, 5'd12), 5'd12, 32'h0000_0000, 1'b1);
    add_entry(r_type_word(7'h00, 5'd12, 5'd9, 3'b110, 5'd26), 5'd26, 32'h2468_acf1, 1'b0);
  endtask

  // hold each word until the edge that takes it
  task automatic run_table();
    for (int idx = 0; idx < NUM_TESTS; idx++) begin
      if (idx == NUM_TESTS / 3) begin
        random_phase <= 1'b1;
      end
      in_valid <= 1'b1;
      inst     <= inst_tab[idx];
      do begin
        @(posedge clk);
      end while (!in_ready);
    end
    in_valid <= 1'b0;
  endtask

  // output stalls about one cycle in four once random
  always @(posedge clk) begin
    if (rst || !random_phase) begin
      out_ready <= 1'b1;
    end else begin
      rnd = $random(seed);
      out_ready <= (rnd[1:0] != 2'b00);
    end
  end

  initial begin
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    run_table();
    while (result_count < NUM_TESTS) @(negedge clk);
    repeat (2) @(negedge clk);
    $display("results checked %0d of %0d, errors %0d", result_count, NUM_TESTS, error_count);
    if (error_count == 0 && result_count == NUM_TESTS) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d results received",
             RESET_CYCLES + WATCHDOG_CYCLES, result_count, NUM_TESTS);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
